// File: filelist.f
source/tcdm_pkg.sv
source/soc_map_pkg.sv
source/tcdm_region_demux.sv
source/tcdm_error_slave.sv
source/tcdm_intlv_guard.sv
source/interleaved_crossbar.sv
source/contiguous_crossbar.sv
source/soc_interconnect.sv
verification/tb_soc_interconnect.sv

// File: Makefile
TOP := tb_soc_interconnect

.PHONY: simulate clean

simulate:
	verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: verification/tb_soc_interconnect.sv
`timescale 1ns/1ps

module tb_soc_interconnect;
    import tcdm_pkg::*;
    import soc_map_pkg::*;

    localparam int NR_MST     = 3;
    localparam int NR_SLV     = 6;
    localparam int NR_TRANS   = 200;
    localparam int MAX_CYCLES = NR_TRANS * NR_MST * 8;

    logic                              clk_i;
    logic                              reset_i;
    tcdm_req_t [NR_MASTER_PORTS-1:0]   mst_req;
    tcdm_rsp_t [NR_MASTER_PORTS-1:0]   mst_rsp;
    tcdm_req_t                         io_req;
    tcdm_rsp_t                         io_rsp;
    tcdm_req_t [NR_BANKS-1:0]          bank_req;
    tcdm_rsp_t [NR_BANKS-1:0]          bank_rsp;
    tcdm_req_t [NR_CONTIG_SLAVES-1:0]  contig_req;
    tcdm_rsp_t [NR_CONTIG_SLAVES-1:0]  contig_rsp;

    // Masters 0 and 1 are the full masters, master 2 is interleaved only
    tcdm_req_t m_req [NR_MST];
    tcdm_rsp_t m_rsp [NR_MST];
    // Ports 0 to 3 are the banks, ports 4 and 5 the contiguous slaves
    tcdm_req_t s_req [NR_SLV];
    tcdm_rsp_t s_rsp [NR_SLV];

    logic [31:0] lfsr_q;
    // Reference memory keyed by word address
    logic [31:0] ref_mem [logic [29:0]];
    // Slave memories keyed by port index and word address
    logic [31:0] slv_mem [logic [32:0]];

    logic        m_busy   [NR_MST];
    int          m_done   [NR_MST];
    logic        exp_pend [NR_MST];
    logic        exp_err  [NR_MST];
    logic        exp_chk  [NR_MST];
    logic [31:0] exp_data [NR_MST];
    logic        s_pend   [NR_SLV];
    logic [31:0] s_data   [NR_SLV];
    int          errors;
    int          checks;
    int          cycles;

    assign mst_req    = {m_req[1], m_req[0]};
    assign io_req     = m_req[2];
    assign m_rsp[0]   = mst_rsp[0];
    assign m_rsp[1]   = mst_rsp[1];
    assign m_rsp[2]   = io_rsp;
    assign bank_rsp   = {s_rsp[3], s_rsp[2], s_rsp[1], s_rsp[0]};
    assign contig_rsp = {s_rsp[5], s_rsp[4]};
    assign s_req[0]   = bank_req[0];
    assign s_req[1]   = bank_req[1];
    assign s_req[2]   = bank_req[2];
    assign s_req[3]   = bank_req[3];
    assign s_req[4]   = contig_req[0];
    assign s_req[5]   = contig_req[1];

    soc_interconnect uut (
        .clk_i             ( clk_i      ),
        .reset_i           ( reset_i    ),
        .mst_req_i         ( mst_req    ),
        .mst_rsp_o         ( mst_rsp    ),
        .intlvd_only_req_i ( io_req     ),
        .intlvd_only_rsp_o ( io_rsp     ),
        .bank_req_o        ( bank_req   ),
        .bank_rsp_i        ( bank_rsp   ),
        .contig_req_o      ( contig_req ),
        .contig_rsp_i      ( contig_rsp )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR, stepped once for every bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Content of a word that was never written, all address bits take part
    function automatic logic [31:0] fill_word(input logic [29:0] w);
        return {w[13:0], w[29:12]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [31:0] merge_be(input logic [31:0] old, input logic [31:0] wd,
                                             input logic [3:0] be);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = be[b] ? wd[8*b +: 8] : old[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic in_intlv(input logic [31:0] a);
        return (a >= INTLVD_BASE) && (a < INTLVD_BASE + INTLVD_SIZE);
    endfunction

    function automatic logic in_contig(input logic [31:0] a, input logic s);
        return (a >= CONTIG_BASE[s]) && (a < CONTIG_BASE[s] + CONTIG_SIZE);
    endfunction

    function automatic logic all_done();
        logic d;
        d = 1'b1;
        for (int m = 0; m < NR_MST; m++) begin
            if (m_done[m] != NR_TRANS || exp_pend[m]) begin
                d = 1'b0;
            end
        end
        return d;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Each master owns words m*64 up to m*64+63 of every region
    task automatic new_request(input int m);
        logic [31:0] sel;
        logic [31:0] word;
        logic [31:0] t;
        sel  = rand_bits(2);
        word = 32'(m) * 32'd64 + rand_bits(6);
        t    = rand_bits(1);
        case (sel)
            32'd0, 32'd1: m_req[m].add = INTLVD_BASE + (word << 2);
            32'd2:        m_req[m].add = CONTIG_BASE[t[0]] + (word << 2);
            default:      m_req[m].add = 32'h3000_0000 + (word << 2);
        endcase
        m_req[m].req   = 1'b1;
        m_req[m].wen   = (rand_bits(1) != 32'd0);
        m_req[m].wdata = rand_bits(32);
        t              = rand_bits(4);
        m_req[m].be    = t[3:0];
    endtask

    // Runs on the falling edge, requests stay put while a master waits
    task automatic drive_inputs();
        for (int m = 0; m < NR_MST; m++) begin
            if (!m_busy[m]) begin
                if (m_done[m] < NR_TRANS && rand_bits(1) != 32'd0) begin
                    new_request(m);
                    m_busy[m] = 1'b1;
                end else begin
                    m_req[m] = '0;
                end
            end
        end
        // Slaves grant at random and answer the grant of the last cycle
        for (int k = 0; k < NR_SLV; k++) begin
            s_rsp[k].gnt     = (rand_bits(1) != 32'd0);
            s_rsp[k].r_valid = s_pend[k];
            s_rsp[k].r_rdata = s_pend[k] ? s_data[k] : '0;
            s_rsp[k].r_opc   = 1'b0;
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Works out the response due one cycle after a grant to master m
    task automatic expect_response(input int m);
        logic [31:0] a;
        logic        mapped;
        a      = m_req[m].add;
        mapped = in_intlv(a) ||
                 (m < NR_MASTER_PORTS && (in_contig(a, 1'b0) || in_contig(a, 1'b1)));
        exp_err[m] = !mapped;
        exp_chk[m] = !mapped || m_req[m].wen;
        if (!mapped) begin
            exp_data[m] = ERROR_WORD;
        end else begin
            if (!ref_mem.exists(a[31:2])) begin
                ref_mem[a[31:2]] = fill_word(a[31:2]);
            end
            if (m_req[m].wen) begin
                exp_data[m] = ref_mem[a[31:2]];
            end else begin
                ref_mem[a[31:2]] = merge_be(ref_mem[a[31:2]], m_req[m].wdata, m_req[m].be);
            end
        end
    endtask

    ////////////////////
    // Checks
    ////////////////////

    // Runs just before the rising edge, when every output has settled
    task automatic check_cycle();
        string       name;
        logic        any_slv;
        logic [32:0] key;
        any_slv = 1'b0;
        for (int m = 0; m < NR_MST; m++) begin
            name = (m < NR_MASTER_PORTS) ? $sformatf("mst_rsp_o[%0d]", m) : "intlvd_only_rsp_o";
            checks++;
            if (m_rsp[m].r_valid != exp_pend[m]) begin
                report_mismatch({name, ".r_valid"}, 32'(exp_pend[m]), 32'(m_rsp[m].r_valid));
            end else if (exp_pend[m]) begin
                if (m_rsp[m].r_opc != exp_err[m]) begin
                    report_mismatch({name, ".r_opc"}, 32'(exp_err[m]), 32'(m_rsp[m].r_opc));
                end
                if (exp_chk[m] && m_rsp[m].r_rdata != exp_data[m]) begin
                    report_mismatch({name, ".r_rdata"}, exp_data[m], m_rsp[m].r_rdata);
                end
            end
            if (m_rsp[m].gnt && !m_req[m].req) begin
                report_failure({name, " raised gnt without a request"});
            end
            exp_pend[m] = m_req[m].req && m_rsp[m].gnt;
            if (exp_pend[m]) begin
                expect_response(m);
                m_busy[m] = 1'b0;
                m_done[m]++;
            end
        end
        for (int k = 0; k < NR_SLV; k++) begin
            s_pend[k] = 1'b0;
            if (s_req[k].req) begin
                any_slv = 1'b1;
                checks++;
                if (k < NR_BANKS) begin
                    if (!in_intlv(s_req[k].add) || s_req[k].add[3:2] != 2'(k)) begin
                        report_failure($sformatf("bank %0d received address %h",
                                                 k, s_req[k].add));
                    end
                end else if (!in_contig(s_req[k].add, k == NR_BANKS + 1)) begin
                    report_failure($sformatf("contiguous slave %0d received address %h",
                                             k - NR_BANKS, s_req[k].add));
                end
                // Behavioural memory acts on the granted request
                if (s_rsp[k].gnt) begin
                    key = {3'(k), s_req[k].add[31:2]};
                    if (!slv_mem.exists(key)) begin
                        slv_mem[key] = fill_word(s_req[k].add[31:2]);
                    end
                    if (!s_req[k].wen) begin
                        slv_mem[key] = merge_be(slv_mem[key], s_req[k].wdata, s_req[k].be);
                    end
                    s_data[k] = slv_mem[key];
                    s_pend[k] = 1'b1;
                end
            end
        end
        if (any_slv && !m_req[0].req && !m_req[1].req && !m_req[2].req) begin
            report_failure("a slave port shows req while no master requests");
        end
    endtask

    initial begin
        lfsr_q  = 32'd65;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        reset_i = 1'b1;
        for (int m = 0; m < NR_MST; m++) begin
            m_req[m]    = '0;
            m_busy[m]   = 1'b0;
            m_done[m]   = 0;
            exp_pend[m] = 1'b0;
            exp_err[m]  = 1'b0;
            exp_chk[m]  = 1'b0;
            exp_data[m] = '0;
        end
        for (int k = 0; k < NR_SLV; k++) begin
            s_rsp[k]  = '0;
            s_pend[k] = 1'b0;
            s_data[k] = '0;
        end
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;
        while (!all_done() && cycles < MAX_CYCLES) begin
            drive_inputs();
            #1;
            check_cycle();
            cycles++;
            @(negedge clk_i);
        end
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("timeout, transactions did not finish in %0d cycles",
                                     MAX_CYCLES));
        end
        $display("cycles: %0d, checks: %0d, errors: %0d", cycles, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: source/soc_interconnect.sv
`timescale 1ns/1ps

module soc_interconnect (
    input  logic                                                    clk_i,
    input  logic                                                    reset_i,
    input  tcdm_pkg::tcdm_req_t [soc_map_pkg::NR_MASTER_PORTS-1:0]  mst_req_i,
    output tcdm_pkg::tcdm_rsp_t [soc_map_pkg::NR_MASTER_PORTS-1:0]  mst_rsp_o,
    input  tcdm_pkg::tcdm_req_t                                     intlvd_only_req_i,
    output tcdm_pkg::tcdm_rsp_t                                     intlvd_only_rsp_o,
    output tcdm_pkg::tcdm_req_t [soc_map_pkg::NR_BANKS-1:0]         bank_req_o,
    input  tcdm_pkg::tcdm_rsp_t [soc_map_pkg::NR_BANKS-1:0]         bank_rsp_i,
    output tcdm_pkg::tcdm_req_t [soc_map_pkg::NR_CONTIG_SLAVES-1:0] contig_req_o,
    input  tcdm_pkg::tcdm_rsp_t [soc_map_pkg::NR_CONTIG_SLAVES-1:0] contig_rsp_i
);
    import tcdm_pkg::*;
    import soc_map_pkg::*;

    tcdm_req_t [NR_MASTER_PORTS-1:0]   demux_intlv_req;
    tcdm_rsp_t [NR_MASTER_PORTS-1:0]   demux_intlv_rsp;
    tcdm_req_t [NR_MASTER_PORTS-1:0]   demux_contig_req;
    tcdm_rsp_t [NR_MASTER_PORTS-1:0]   demux_contig_rsp;
    tcdm_req_t                         guard_req;
    tcdm_rsp_t                         guard_rsp;
    tcdm_req_t [NR_INTLVD_MASTERS-1:0] xbar_mst_req;
    tcdm_rsp_t [NR_INTLVD_MASTERS-1:0] xbar_mst_rsp;
    tcdm_req_t                         err_req;
    tcdm_rsp_t                         err_rsp;

    ////////////////////
    // Region split
    ////////////////////

    // Full masters choose between interleaved and contiguous space
    for (genvar i = 0; i < NR_MASTER_PORTS; i++) begin : gen_region_demux
        tcdm_region_demux i_region_demux (
            .clk_i       ( clk_i               ),
            .reset_i     ( reset_i             ),
            .mst_req_i   ( mst_req_i[i]        ),
            .mst_rsp_o   ( mst_rsp_o[i]        ),
            .intlv_req_o ( demux_intlv_req[i]  ),
            .other_req_o ( demux_contig_req[i] ),
            .intlv_rsp_i ( demux_intlv_rsp[i]  ),
            .other_rsp_i ( demux_contig_rsp[i] )
        );
    end

    // The interleaved-only master is fenced off from everything else
    tcdm_intlv_guard i_intlv_guard (
        .clk_i      ( clk_i             ),
        .reset_i    ( reset_i           ),
        .mst_req_i  ( intlvd_only_req_i ),
        .mst_rsp_o  ( intlvd_only_rsp_o ),
        .xbar_req_o ( guard_req         ),
        .xbar_rsp_i ( guard_rsp         )
    );

    ////////////////////
    // Crossbars
    ////////////////////

    // Guard output takes the highest master index of the interleaved crossbar
    assign xbar_mst_req                 = {guard_req, demux_intlv_req};
    assign {guard_rsp, demux_intlv_rsp} = xbar_mst_rsp;

    interleaved_crossbar i_interleaved_xbar (
        .clk_i      ( clk_i        ),
        .reset_i    ( reset_i      ),
        .mst_req_i  ( xbar_mst_req ),
        .mst_rsp_o  ( xbar_mst_rsp ),
        .bank_req_o ( bank_req_o   ),
        .bank_rsp_i ( bank_rsp_i   )
    );

    contiguous_crossbar i_contiguous_xbar (
        .clk_i     ( clk_i            ),
        .reset_i   ( reset_i          ),
        .mst_req_i ( demux_contig_req ),
        .mst_rsp_o ( demux_contig_rsp ),
        .slv_req_o ( contig_req_o     ),
        .slv_rsp_i ( contig_rsp_i     ),
        .err_req_o ( err_req          ),
        .err_rsp_i ( err_rsp          )
    );

    // Answers unmapped contiguous-side accesses with the error word
    tcdm_error_slave i_error_slave (
        .clk_i     ( clk_i   ),
        .reset_i   ( reset_i ),
        .slv_req_i ( err_req ),
        .slv_rsp_o ( err_rsp )
    );

endmodule

// File: source/contiguous_crossbar.sv
`timescale 1ns/1ps

module contiguous_crossbar (
    input  logic                                                    clk_i,
    input  logic                                                    reset_i,
    input  tcdm_pkg::tcdm_req_t [soc_map_pkg::NR_MASTER_PORTS-1:0]  mst_req_i,
    output tcdm_pkg::tcdm_rsp_t [soc_map_pkg::NR_MASTER_PORTS-1:0]  mst_rsp_o,
    output tcdm_pkg::tcdm_req_t [soc_map_pkg::NR_CONTIG_SLAVES-1:0] slv_req_o,
    input  tcdm_pkg::tcdm_rsp_t [soc_map_pkg::NR_CONTIG_SLAVES-1:0] slv_rsp_i,
    output tcdm_pkg::tcdm_req_t                                     err_req_o,
    input  tcdm_pkg::tcdm_rsp_t                                     err_rsp_i
);
    import tcdm_pkg::*;
    import soc_map_pkg::*;

    // Targets are the range-mapped slaves followed by the error port
    tcdm_req_t [NR_CONTIG_TARGETS-1:0]               tgt_req;
    tcdm_rsp_t [NR_CONTIG_TARGETS-1:0]               tgt_rsp;
    logic [NR_MASTER_PORTS-1:0][CONTIG_TGT_W-1:0]    mst_tgt;
    logic [NR_MASTER_PORTS-1:0]                      mst_gnt;
    logic [NR_CONTIG_TARGETS-1:0][NR_MASTER_PORTS-1:0] tgt_rq;
    logic [NR_CONTIG_TARGETS-1:0]                    tgt_any;
    logic [NR_CONTIG_TARGETS-1:0][CONTIG_MST_W-1:0]  tgt_win;
    logic [NR_CONTIG_TARGETS-1:0][CONTIG_MST_W-1:0]  rr_ptr_q;
    logic [NR_MASTER_PORTS-1:0]                      pend_q;
    logic [NR_MASTER_PORTS-1:0][CONTIG_TGT_W-1:0]    pend_tgt_q;

    // Error port sits at the top index of the target arrays
    assign slv_req_o = tgt_req[NR_CONTIG_SLAVES-1:0];
    assign err_req_o = tgt_req[NR_CONTIG_SLAVES];
    assign tgt_rsp   = {err_rsp_i, slv_rsp_i};

    ////////////////////
    // Range decode
    ////////////////////

    // Anything that misses every window falls through to the error port
    always_comb begin
        tgt_rq = '0;
        for (int m = 0; m < NR_MASTER_PORTS; m++) begin
            mst_tgt[m] = CONTIG_TGT_W'(NR_CONTIG_SLAVES);
            for (int s = NR_CONTIG_SLAVES - 1; s >= 0; s--) begin
                if ((mst_req_i[m].add - CONTIG_BASE[s]) < CONTIG_SIZE) begin
                    mst_tgt[m] = CONTIG_TGT_W'(s);
                end
            end
            tgt_rq[mst_tgt[m]][m] = mst_req_i[m].req;
        end
    end

    ////////////////////
    // Arbitration
    ////////////////////

    // Round robin per target, starting the search at the pointer
    always_comb begin
        int unsigned idx;
        for (int t = 0; t < NR_CONTIG_TARGETS; t++) begin
            tgt_win[t] = '0;
            tgt_any[t] = |tgt_rq[t];
            for (int k = NR_MASTER_PORTS - 1; k >= 0; k--) begin
                idx = (int'(rr_ptr_q[t]) + k) % NR_MASTER_PORTS;
                if (tgt_rq[t][idx]) begin
                    tgt_win[t] = CONTIG_MST_W'(idx);
                end
            end
            tgt_req[t]     = mst_req_i[tgt_win[t]];
            tgt_req[t].req = tgt_any[t];
        end
    end

    ////////////////////
    // Responses
    ////////////////////

    always_comb begin
        for (int m = 0; m < NR_MASTER_PORTS; m++) begin
            mst_gnt[m] = tgt_any[mst_tgt[m]] & tgt_rsp[mst_tgt[m]].gnt &
                         (tgt_win[mst_tgt[m]] == CONTIG_MST_W'(m));
            mst_rsp_o[m]     = '0;
            mst_rsp_o[m].gnt = mst_gnt[m];
            if (pend_q[m]) begin
                mst_rsp_o[m].r_valid = tgt_rsp[pend_tgt_q[m]].r_valid;
                mst_rsp_o[m].r_rdata = tgt_rsp[pend_tgt_q[m]].r_rdata;
                mst_rsp_o[m].r_opc   = tgt_rsp[pend_tgt_q[m]].r_opc;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q <= '0;
            pend_q   <= '0;
        end else begin
            pend_q <= mst_gnt;
            for (int t = 0; t < NR_CONTIG_TARGETS; t++) begin
                if (tgt_any[t] && tgt_rsp[t].gnt) begin
                    if (tgt_win[t] == CONTIG_MST_W'(NR_MASTER_PORTS - 1)) begin
                        rr_ptr_q[t] <= '0;
                    end else begin
                        rr_ptr_q[t] <= tgt_win[t] + 1'b1;
                    end
                end
            end
        end
    end

    // Target of the last grant, used to steer the response one cycle on
    always_ff @(posedge clk_i) begin
        for (int m = 0; m < NR_MASTER_PORTS; m++) begin
            if (mst_gnt[m]) begin
                pend_tgt_q[m] <= mst_tgt[m];
            end
        end
    end

endmodule

// File: source/interleaved_crossbar.sv
`timescale 1ns/1ps

module interleaved_crossbar (
    input  logic                                                     clk_i,
    input  logic                                                     reset_i,
    input  tcdm_pkg::tcdm_req_t [soc_map_pkg::NR_INTLVD_MASTERS-1:0] mst_req_i,
    output tcdm_pkg::tcdm_rsp_t [soc_map_pkg::NR_INTLVD_MASTERS-1:0] mst_rsp_o,
    output tcdm_pkg::tcdm_req_t [soc_map_pkg::NR_BANKS-1:0]          bank_req_o,
    input  tcdm_pkg::tcdm_rsp_t [soc_map_pkg::NR_BANKS-1:0]          bank_rsp_i
);
    import tcdm_pkg::*;
    import soc_map_pkg::*;

    tcdm_addr_u [NR_INTLVD_MASTERS-1:0]               mst_addr;
    logic [NR_INTLVD_MASTERS-1:0][BANK_SEL_WIDTH-1:0] mst_bank;
    logic [NR_INTLVD_MASTERS-1:0]                     mst_gnt;
    // Request matrix with one row of masters per bank
    logic [NR_BANKS-1:0][NR_INTLVD_MASTERS-1:0]       bank_rq;
    logic [NR_BANKS-1:0]                              bank_any;
    logic [NR_BANKS-1:0][INTLVD_MST_W-1:0]            bank_win;
    logic [NR_BANKS-1:0][INTLVD_MST_W-1:0]            rr_ptr_q;
    logic [NR_INTLVD_MASTERS-1:0]                     pend_q;
    logic [NR_INTLVD_MASTERS-1:0][BANK_SEL_WIDTH-1:0] pend_bank_q;

    ////////////////////
    // Bank decode
    ////////////////////

    // Word interleaving sends consecutive words to consecutive banks
    always_comb begin
        bank_rq = '0;
        for (int m = 0; m < NR_INTLVD_MASTERS; m++) begin
            mst_addr[m].flat           = mst_req_i[m].add;
            mst_bank[m]                = mst_addr[m].view.bank_idx;
            bank_rq[mst_bank[m]][m]    = mst_req_i[m].req;
        end
    end

    ////////////////////
    // Arbitration
    ////////////////////

    // Search from the pointer upwards
    // The last hit in the descending loop is the one closest to the pointer
    always_comb begin
        int unsigned idx;
        for (int b = 0; b < NR_BANKS; b++) begin
            bank_win[b] = '0;
            bank_any[b] = |bank_rq[b];
            for (int k = NR_INTLVD_MASTERS - 1; k >= 0; k--) begin
                idx = (int'(rr_ptr_q[b]) + k) % NR_INTLVD_MASTERS;
                if (bank_rq[b][idx]) begin
                    bank_win[b] = INTLVD_MST_W'(idx);
                end
            end
            // The winner's payload goes through without any register
            bank_req_o[b]     = mst_req_i[bank_win[b]];
            bank_req_o[b].req = bank_any[b];
        end
    end

    ////////////////////
    // Responses
    ////////////////////

    always_comb begin
        for (int m = 0; m < NR_INTLVD_MASTERS; m++) begin
            mst_gnt[m] = bank_any[mst_bank[m]] & bank_rsp_i[mst_bank[m]].gnt &
                         (bank_win[mst_bank[m]] == INTLVD_MST_W'(m));
            mst_rsp_o[m]     = '0;
            mst_rsp_o[m].gnt = mst_gnt[m];
            // Read data comes from the bank granted in the previous cycle
            if (pend_q[m]) begin
                mst_rsp_o[m].r_valid = bank_rsp_i[pend_bank_q[m]].r_valid;
                mst_rsp_o[m].r_rdata = bank_rsp_i[pend_bank_q[m]].r_rdata;
                mst_rsp_o[m].r_opc   = bank_rsp_i[pend_bank_q[m]].r_opc;
            end
        end
    end

    // Pointer moves just past the winner whenever the bank grants
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_ptr_q <= '0;
            pend_q   <= '0;
        end else begin
            pend_q <= mst_gnt;
            for (int b = 0; b < NR_BANKS; b++) begin
                if (bank_any[b] && bank_rsp_i[b].gnt) begin
                    if (bank_win[b] == INTLVD_MST_W'(NR_INTLVD_MASTERS - 1)) begin
                        rr_ptr_q[b] <= '0;
                    end else begin
                        rr_ptr_q[b] <= bank_win[b] + 1'b1;
                    end
                end
            end
        end
    end

    // Bank of the last grant steers the response in the next cycle
    always_ff @(posedge clk_i) begin
        for (int m = 0; m < NR_INTLVD_MASTERS; m++) begin
            if (mst_gnt[m]) begin
                pend_bank_q[m] <= mst_bank[m];
            end
        end
    end

endmodule

// File: source/tcdm_intlv_guard.sv
`timescale 1ns/1ps

module tcdm_intlv_guard (
    input  logic                clk_i,
    input  logic                reset_i,
    input  tcdm_pkg::tcdm_req_t mst_req_i,
    output tcdm_pkg::tcdm_rsp_t mst_rsp_o,
    output tcdm_pkg::tcdm_req_t xbar_req_o,
    input  tcdm_pkg::tcdm_rsp_t xbar_rsp_i
);
    import tcdm_pkg::*;

    // Everything outside the interleaved region lands on this link
    tcdm_req_t err_req;
    tcdm_rsp_t err_rsp;

    // Same region split as for the full masters
    tcdm_region_demux i_region_demux (
        .clk_i       ( clk_i      ),
        .reset_i     ( reset_i    ),
        .mst_req_i   ( mst_req_i  ),
        .mst_rsp_o   ( mst_rsp_o  ),
        .intlv_req_o ( xbar_req_o ),
        .other_req_o ( err_req    ),
        .intlv_rsp_i ( xbar_rsp_i ),
        .other_rsp_i ( err_rsp    )
    );

    // Private error slave, so this master never sees the contiguous space
    tcdm_error_slave i_error_slave (
        .clk_i     ( clk_i   ),
        .reset_i   ( reset_i ),
        .slv_req_i ( err_req ),
        .slv_rsp_o ( err_rsp )
    );

endmodule

// File: source/tcdm_error_slave.sv
`timescale 1ns/1ps

module tcdm_error_slave (
    input  logic                clk_i,
    input  logic                reset_i,
    input  tcdm_pkg::tcdm_req_t slv_req_i,
    output tcdm_pkg::tcdm_rsp_t slv_rsp_o
);
    import soc_map_pkg::*;

    // High in the cycle that follows a granted request
    logic rsp_valid_q;

    // Every request is accepted at once, there is never back-pressure here
    assign slv_rsp_o.gnt     = slv_req_i.req;
    assign slv_rsp_o.r_valid = rsp_valid_q;
    // Reads and writes alike get the error word, r_opc flags the failure
    assign slv_rsp_o.r_rdata = ERROR_WORD;
    assign slv_rsp_o.r_opc   = rsp_valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= slv_req_i.req;
        end
    end

endmodule

// File: source/tcdm_region_demux.sv
`timescale 1ns/1ps

module tcdm_region_demux (
    input  logic                clk_i,
    input  logic                reset_i,
    input  tcdm_pkg::tcdm_req_t mst_req_i,
    output tcdm_pkg::tcdm_rsp_t mst_rsp_o,
    output tcdm_pkg::tcdm_req_t intlv_req_o,
    output tcdm_pkg::tcdm_req_t other_req_o,
    input  tcdm_pkg::tcdm_rsp_t intlv_rsp_i,
    input  tcdm_pkg::tcdm_rsp_t other_rsp_i
);
    import soc_map_pkg::*;

    logic sel_intlv;
    // One bit per side, set in the cycle after that side granted
    logic pend_intlv_q;
    logic pend_other_q;

    // Unsigned wrap makes addresses below the base fail the compare as well
    assign sel_intlv = (mst_req_i.add - INTLVD_BASE) < INTLVD_SIZE;

    // Both sides see the payload but only one of them sees req
    always_comb begin
        intlv_req_o     = mst_req_i;
        intlv_req_o.req = mst_req_i.req & sel_intlv;
        other_req_o     = mst_req_i;
        other_req_o.req = mst_req_i.req & ~sel_intlv;
    end

    always_comb begin
        mst_rsp_o     = '0;
        // Grant comes straight from whichever side got the request
        mst_rsp_o.gnt = sel_intlv ? intlv_rsp_i.gnt : other_rsp_i.gnt;
        if (pend_intlv_q) begin
            mst_rsp_o.r_valid = intlv_rsp_i.r_valid;
            mst_rsp_o.r_rdata = intlv_rsp_i.r_rdata;
            mst_rsp_o.r_opc   = intlv_rsp_i.r_opc;
        end else if (pend_other_q) begin
            mst_rsp_o.r_valid = other_rsp_i.r_valid;
            mst_rsp_o.r_rdata = other_rsp_i.r_rdata;
            mst_rsp_o.r_opc   = other_rsp_i.r_opc;
        end
    end

    // Remember the granting side so the response one cycle later is
    // taken from the right place
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_intlv_q <= 1'b0;
            pend_other_q <= 1'b0;
        end else begin
            pend_intlv_q <= mst_req_i.req & mst_rsp_o.gnt & sel_intlv;
            pend_other_q <= mst_req_i.req & mst_rsp_o.gnt & ~sel_intlv;
        end
    end

endmodule

// File: source/soc_map_pkg.sv
package soc_map_pkg;

    // Master and slave counts of the interconnect
    localparam int unsigned NR_MASTER_PORTS             = 2;
    localparam int unsigned NR_MASTER_PORTS_INTLVD_ONLY = 1;
    localparam int unsigned NR_INTLVD_MASTERS           =
        NR_MASTER_PORTS + NR_MASTER_PORTS_INTLVD_ONLY;
    localparam int unsigned NR_BANKS                    = 4;
    localparam int unsigned NR_CONTIG_SLAVES            = 2;

    // The contiguous crossbar has one extra target, the default error port
    localparam int unsigned NR_CONTIG_TARGETS = NR_CONTIG_SLAVES + 1;

    // Index widths for arbiters and response steering
    localparam int unsigned INTLVD_MST_W = $clog2(NR_INTLVD_MASTERS);
    localparam int unsigned CONTIG_MST_W = $clog2(NR_MASTER_PORTS);
    localparam int unsigned CONTIG_TGT_W = $clog2(NR_CONTIG_TARGETS);

    // Interleaved region, 64 KiB spread over all banks
    localparam logic [tcdm_pkg::ADDR_WIDTH-1:0] INTLVD_BASE = 32'h1C00_0000;
    localparam logic [tcdm_pkg::ADDR_WIDTH-1:0] INTLVD_SIZE = 32'h0001_0000;

    // Contiguous slaves, each one owns a 4 KiB window
    localparam logic [NR_CONTIG_SLAVES-1:0][tcdm_pkg::ADDR_WIDTH-1:0] CONTIG_BASE = {
        32'h1A11_0000,
        32'h1A10_0000
    };
    localparam logic [tcdm_pkg::ADDR_WIDTH-1:0] CONTIG_SIZE = 32'h0000_1000;

    // Read data returned together with r_opc on every bus error
    localparam logic [tcdm_pkg::DATA_WIDTH-1:0] ERROR_WORD = 32'hBADA_CCE5;

endpackage

// File: source/tcdm_pkg.sv
package tcdm_pkg;

    // Bus widths shared by every TCDM link in the interconnect
    localparam int unsigned ADDR_WIDTH     = 32;
    localparam int unsigned DATA_WIDTH     = 32;
    localparam int unsigned BE_WIDTH       = 4;

    // Byte offset inside a word and the interleaving field above it
    localparam int unsigned BYTE_OFF_WIDTH = $clog2(BE_WIDTH);
    localparam int unsigned BANK_SEL_WIDTH = 2;

    // Request travelling from a master towards a slave
    // The master keeps every field stable until it sees gnt
    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] add;
        // Active low, so a one here marks a read
        logic                  wen;
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
    } tcdm_req_t;

    // Response travelling back, r_valid trails gnt by exactly one cycle
    typedef struct packed {
        logic                  gnt;
        logic                  r_valid;
        logic [DATA_WIDTH-1:0] r_rdata;
        logic                  r_opc;
    } tcdm_rsp_t;

    // Word interleaving picks the bank from the lowest word address bits
    typedef struct packed {
        logic [ADDR_WIDTH-BANK_SEL_WIDTH-BYTE_OFF_WIDTH-1:0] upper;
        logic [BANK_SEL_WIDTH-1:0]                           bank_idx;
        logic [BYTE_OFF_WIDTH-1:0]                           offset;
    } tcdm_bank_view_t;

    // One address word read either flat or split for bank selection
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        tcdm_bank_view_t       view;
    } tcdm_addr_u;

endpackage
